// File: common/enc_ctx_pkg.sv
// code context types: puncture mode enum and code identifier

package enc_ctx_pkg;

  // ------------------------------------------------------------
  // puncture mode
  // ------------------------------------------------------------

  // sampled with isof, held for the whole block
  // PUNCT_ON drops the first systematic words of the block
  typedef enum logic {
    PUNCT_OFF = 1'b0,
    PUNCT_ON  = 1'b1
  } punct_mode_t;

  // ------------------------------------------------------------
  // code identifier
  // ------------------------------------------------------------

  // opaque to the encoder itself
  // only latched at start of frame and passed to the write side
  typedef logic [1:0] code_id_t;

endpackage

// File: common/enc_defines.svh
// encoder width macros: data word, output address, tag and puncture word count

`ifndef ENC_DEFINES_SVH
`define ENC_DEFINES_SVH

// ------------------------------------------------------------
// data path
// ------------------------------------------------------------

// width of one data word on the input and the output
`define ENC_DAT_W 8

// width of the output word address
// one block with its parity has to fit into this range
`define ENC_ADDR_W 8

// ------------------------------------------------------------
// frame context
// ------------------------------------------------------------

// tag carried from isof to every write of the block
`define ENC_TAG_W 2

// leading systematic words removed when puncturing is on
`define ENC_PUNCT_WORDS 2

`endif

// File: common/enc_word_pkg.sv
// data word type and parity emission state enum

`include "enc_defines.svh"

package enc_word_pkg;

  // ------------------------------------------------------------
  // data word
  // ------------------------------------------------------------

  // same width for systematic and parity words
  typedef logic [`ENC_DAT_W-1:0] dat_t;

  // ------------------------------------------------------------
  // parity emission
  // ------------------------------------------------------------

  // idle while accumulating, then one state per parity word
  typedef enum logic [1:0] {
    PAR_IDLE = 2'd0,
    PAR_P1   = 2'd1,
    PAR_P2   = 2'd2,
    PAR_P3   = 2'd3
  } par_state_t;

endpackage

// File: design/enc_muxout.sv
// systematic/parity output mux, write address counter and frame-full pulse

`timescale 1ns/1ps

`include "enc_defines.svh"

module enc_muxout (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  //
  input  logic                      sys_val,
  input  logic                      sys_sof,
  input  logic                      sys_pmask,
  input  enc_word_pkg::dat_t        sys_dat,
  input  enc_ctx_pkg::punct_mode_t  sys_punct,
  input  logic [`ENC_TAG_W-1:0]     sys_tag,
  input  enc_ctx_pkg::code_id_t     sys_code_id,
  //
  input  logic                      p1_val,
  input  enc_word_pkg::dat_t        p1_dat,
  input  logic                      p2_val,
  input  enc_word_pkg::dat_t        p2_dat,
  input  logic                      p3_val,
  input  enc_word_pkg::dat_t        p3_dat,
  input  logic                      p3_eof,
  //
  output logic                      owrite,
  output logic [`ENC_ADDR_W-1:0]    owaddr,
  output enc_word_pkg::dat_t        owdat,
  output logic                      owfull,
  output logic [`ENC_TAG_W-1:0]     owtag,
  output enc_ctx_pkg::code_id_t     ocode_id
);

  // ------------------------------------------------------------
  // mux stage
  // ------------------------------------------------------------

  logic               sys_drop;
  logic               mux_write;
  logic               mux_wstart;
  logic               mux_wfull;
  enc_word_pkg::dat_t mux_wdat;

  // masked word is only removed when the block asks for puncturing
  assign sys_drop   = sys_pmask & (sys_punct == enc_ctx_pkg::PUNCT_ON);
  assign mux_wstart = sys_val & sys_sof;
  assign mux_wfull  = p3_val & p3_eof;
  assign mux_write  = (sys_val & !sys_drop) | p1_val | p2_val | p3_val;

  // parity wins over data, later parity over earlier
  always_comb begin
    mux_wdat = sys_dat;
    if (p3_val) begin
      mux_wdat = p3_dat;
    end else if (p2_val) begin
      mux_wdat = p2_dat;
    end else if (p1_val) begin
      mux_wdat = p1_dat;
    end
  end

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      owfull <= 1'b0;
      owaddr <= '0;
    end else if (iclkena) begin
      owrite <= mux_write;
      owfull <= mux_wfull;
      // sof zeroes the address even for a punctured first word,
      // so the first real write still lands at 0
      owaddr <= mux_wstart ? '0 : (owaddr + owrite);
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      owdat <= mux_wdat;
      if (mux_wstart) begin
        owtag    <= sys_tag;
        ocode_id <= sys_code_id;
      end
    end
  end

endmodule

// File: design/enc_top.sv
// encoder top: systematic path, parity path and output mux

`timescale 1ns/1ps

`include "enc_defines.svh"

module enc_top (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  //
  input  logic                      ival,
  input  logic                      isof,
  input  logic                      ieof,
  input  enc_word_pkg::dat_t        idat,
  input  logic [`ENC_TAG_W-1:0]     itag,
  input  enc_ctx_pkg::punct_mode_t  ipunct,
  input  enc_ctx_pkg::code_id_t     icode_id,
  //
  output logic                      owrite,
  output logic [`ENC_ADDR_W-1:0]    owaddr,
  output enc_word_pkg::dat_t        owdat,
  output logic                      owfull,
  output logic [`ENC_TAG_W-1:0]     owtag,
  output enc_ctx_pkg::code_id_t     ocode_id,
  output logic                      obusy
);

  // ------------------------------------------------------------
  // systematic path
  // ------------------------------------------------------------

  logic                      sys_val;
  logic                      sys_sof;
  logic                      sys_pmask;
  enc_word_pkg::dat_t        sys_dat;
  enc_ctx_pkg::punct_mode_t  sys_punct;
  logic [`ENC_TAG_W-1:0]     sys_tag;
  enc_ctx_pkg::code_id_t     sys_code_id;

  enc_sys_path i_sys_path (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .ival        (ival),
    .isof        (isof),
    .idat        (idat),
    .itag        (itag),
    .ipunct      (ipunct),
    .icode_id    (icode_id),
    .sys_val     (sys_val),
    .sys_sof     (sys_sof),
    .sys_pmask   (sys_pmask),
    .sys_dat     (sys_dat),
    .sys_punct   (sys_punct),
    .sys_tag     (sys_tag),
    .sys_code_id (sys_code_id)
  );

  // ------------------------------------------------------------
  // parity path
  // ------------------------------------------------------------

  logic               p1_val;
  enc_word_pkg::dat_t p1_dat;
  logic               p2_val;
  enc_word_pkg::dat_t p2_dat;
  logic               p3_val;
  enc_word_pkg::dat_t p3_dat;
  logic               p3_eof;

  // fed from the raw input, same as the systematic register
  enc_parity i_parity (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isof    (isof),
    .ieof    (ieof),
    .idat    (idat),
    .p1_val  (p1_val),
    .p1_dat  (p1_dat),
    .p2_val  (p2_val),
    .p2_dat  (p2_dat),
    .p3_val  (p3_val),
    .p3_dat  (p3_dat),
    .p3_eof  (p3_eof),
    .obusy   (obusy)
  );

  // ------------------------------------------------------------
  // output mux
  // ------------------------------------------------------------

  enc_muxout i_muxout (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .sys_val     (sys_val),
    .sys_sof     (sys_sof),
    .sys_pmask   (sys_pmask),
    .sys_dat     (sys_dat),
    .sys_punct   (sys_punct),
    .sys_tag     (sys_tag),
    .sys_code_id (sys_code_id),
    .p1_val      (p1_val),
    .p1_dat      (p1_dat),
    .p2_val      (p2_val),
    .p2_dat      (p2_dat),
    .p3_val      (p3_val),
    .p3_dat      (p3_dat),
    .p3_eof      (p3_eof),
    .owrite      (owrite),
    .owaddr      (owaddr),
    .owdat       (owdat),
    .owfull      (owfull),
    .owtag       (owtag),
    .ocode_id    (ocode_id)
  );

endmodule

// File: enc_parity/enc_parity.sv
// parity accumulator with three XOR rules and the three-word parity emitter

`timescale 1ns/1ps

`include "enc_defines.svh"

module enc_parity (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  //
  input  logic                ival,
  input  logic                isof,
  input  logic                ieof,
  input  enc_word_pkg::dat_t  idat,
  //
  output logic                p1_val,
  output enc_word_pkg::dat_t  p1_dat,
  output logic                p2_val,
  output enc_word_pkg::dat_t  p2_dat,
  output logic                p3_val,
  output enc_word_pkg::dat_t  p3_dat,
  output logic                p3_eof,
  //
  output logic                obusy
);

  localparam int ROT_W = $clog2(`ENC_DAT_W);

  // ------------------------------------------------------------
  // declarations
  // ------------------------------------------------------------

  enc_word_pkg::par_state_t   state;

  // eof seen on the input, one cycle late
  // keeps the parity words behind the systematic register stage
  logic                       eof_d;

  // word position inside the block
  logic [`ENC_ADDR_W-1:0]     idx_cnt;
  logic [`ENC_ADDR_W-1:0]     cur_idx;
  logic [ROT_W-1:0]           rot_sh;

  enc_word_pkg::dat_t         acc_p1;
  enc_word_pkg::dat_t         acc_p2;
  enc_word_pkg::dat_t         acc_p3;
  enc_word_pkg::dat_t         dat_rot;

  // rotate a word left by sh bits
  function automatic enc_word_pkg::dat_t rotl(input enc_word_pkg::dat_t w,
                                              input logic [ROT_W-1:0] sh);
    // shift by full width gives zero, so sh == 0 passes w unchanged
    return (w << sh) | (w >> (`ENC_DAT_W - sh));
  endfunction

  // ------------------------------------------------------------
  // word index and rotation
  // ------------------------------------------------------------

  // first word of a block is index 0 whatever the counter holds
  assign cur_idx = isof ? '0 : idx_cnt;
  assign rot_sh  = ROT_W'(cur_idx % `ENC_DAT_W);
  assign dat_rot = rotl(idat, rot_sh);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx_cnt <= '0;
    end else if (iclkena) begin
      if (ival) begin
        idx_cnt <= cur_idx + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // accumulators
  // ------------------------------------------------------------

  // p1 xor of all words
  // p2 xor of words rotated by index
  // p3 xor of even index words
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival && isof) begin
        acc_p1 <= idat;
        acc_p2 <= dat_rot;
        acc_p3 <= idat;
      end else if (ival) begin
        acc_p1 <= acc_p1 ^ idat;
        acc_p2 <= acc_p2 ^ dat_rot;
        if (!cur_idx[0]) begin
          acc_p3 <= acc_p3 ^ idat;
        end
      end else if (state == enc_word_pkg::PAR_P3) begin
        // last parity word is out, start clean
        acc_p1 <= '0;
        acc_p2 <= '0;
        acc_p3 <= '0;
      end
    end
  end

  // ------------------------------------------------------------
  // emission fsm
  // ------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      eof_d <= 1'b0;
      state <= enc_word_pkg::PAR_IDLE;
    end else if (iclkena) begin
      eof_d <= ival & ieof;
      case (state)
        enc_word_pkg::PAR_IDLE : if (eof_d) state <= enc_word_pkg::PAR_P1;
        enc_word_pkg::PAR_P1   : state <= enc_word_pkg::PAR_P2;
        enc_word_pkg::PAR_P2   : state <= enc_word_pkg::PAR_P3;
        default                : state <= enc_word_pkg::PAR_IDLE;
      endcase
    end
  end

  // one word per state, valid follows the state
  assign p1_val = (state == enc_word_pkg::PAR_P1);
  assign p2_val = (state == enc_word_pkg::PAR_P2);
  assign p3_val = (state == enc_word_pkg::PAR_P3);
  assign p3_eof = p3_val;

  assign p1_dat = acc_p1;
  assign p2_dat = acc_p2;
  assign p3_dat = acc_p3;

  // three cycles after eof, source may start the next block
  // while p3 is still on its way out
  assign obusy = eof_d | p1_val | p2_val;

endmodule

// File: enc_sys/enc_sys_path.sv
// systematic word register stage with puncture mask and frame context latch

`timescale 1ns/1ps

`include "enc_defines.svh"

module enc_sys_path (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  //
  input  logic                      ival,
  input  logic                      isof,
  input  enc_word_pkg::dat_t        idat,
  input  logic [`ENC_TAG_W-1:0]     itag,
  input  enc_ctx_pkg::punct_mode_t  ipunct,
  input  enc_ctx_pkg::code_id_t     icode_id,
  //
  output logic                      sys_val,
  output logic                      sys_sof,
  output logic                      sys_pmask,
  output enc_word_pkg::dat_t        sys_dat,
  output enc_ctx_pkg::punct_mode_t  sys_punct,
  output logic [`ENC_TAG_W-1:0]     sys_tag,
  output enc_ctx_pkg::code_id_t     sys_code_id
);

  // ------------------------------------------------------------
  // word count for the puncture mask
  // ------------------------------------------------------------

  logic [`ENC_ADDR_W-1:0] word_cnt;
  logic [`ENC_ADDR_W-1:0] cur_idx;
  logic                   in_mask;

  assign cur_idx = isof ? '0 : word_cnt;
  assign in_mask = (cur_idx < `ENC_PUNCT_WORDS);

  // ------------------------------------------------------------
  // control registers
  // ------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      word_cnt  <= '0;
      sys_val   <= 1'b0;
      sys_sof   <= 1'b0;
      sys_pmask <= 1'b0;
      sys_punct <= enc_ctx_pkg::PUNCT_OFF;
    end else if (iclkena) begin
      sys_val   <= ival;
      sys_sof   <= ival & isof;
      sys_pmask <= ival & in_mask;
      // count stops once past the mask, no wrap back into it
      if (ival && in_mask) begin
        word_cnt <= cur_idx + 1'b1;
      end
      if (ival && isof) begin
        sys_punct <= ipunct;
      end
    end
  end

  // ------------------------------------------------------------
  // data and context
  // ------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sys_dat <= idat;
      // held until next start of frame
      if (ival && isof) begin
        sys_tag     <= itag;
        sys_code_id <= icode_id;
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the encoder testbench with Verilator and run it
# exit status is nonzero when the build, the run or the result fails

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module enc_tb -f vlog.f -o enc_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/enc_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$SIM_LOG"; then
  echo "no result line found in $SIM_LOG"
  exit 1
fi
exit 0

// File: tests/enc_tb.sv
// encoder testbench: reference model, stimulus tasks, write monitor and assertions

`timescale 1ns/1ps

`include "enc_defines.svh"

module enc_tb;

  // one expected write on the output stream
  typedef struct packed {
    logic [`ENC_ADDR_W-1:0] addr;
    logic [`ENC_DAT_W-1:0]  dat;
    logic                   full;
    logic [`ENC_TAG_W-1:0]  tag;
    logic [1:0]             code;
    int                     cyc;
  } wr_t;

  logic                     iclk;
  logic                     ireset;
  logic                     iclkena;
  logic                     ival;
  logic                     isof;
  logic                     ieof;
  logic [`ENC_DAT_W-1:0]    idat;
  logic [`ENC_TAG_W-1:0]    itag;
  enc_ctx_pkg::punct_mode_t ipunct;
  enc_ctx_pkg::code_id_t    icode_id;
  logic                     owrite;
  logic [`ENC_ADDR_W-1:0]   owaddr;
  logic [`ENC_DAT_W-1:0]    owdat;
  logic                     owfull;
  logic [`ENC_TAG_W-1:0]    owtag;
  enc_ctx_pkg::code_id_t    ocode_id;
  logic                     obusy;

  wr_t    exp_q[$];
  int     ecnt;
  int     busy_run;
  int     err_cnt;
  int     n_pass;
  int     n_fail;
  bit     aborted;
  integer seed;

  enc_top i_enc_top (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (ival),
    .isof     (isof),
    .ieof     (ieof),
    .idat     (idat),
    .itag     (itag),
    .ipunct   (ipunct),
    .icode_id (icode_id),
    .owrite   (owrite),
    .owaddr   (owaddr),
    .owdat    (owdat),
    .owfull   (owfull),
    .owtag    (owtag),
    .ocode_id (ocode_id),
    .obusy    (obusy)
  );

  // 4 ns period
  always #2 iclk = ~iclk;

  // ------------------------------------------------------------
  // assertions on the write stream
  // ------------------------------------------------------------

  // frame-full only rides on a write
  full_with_write : assert property (@(posedge iclk) disable iff (ireset) owfull |-> owrite)
    else begin
      $display("[ERROR] owfull: expected %h, got %h with owrite low", 1'b0, owfull);
      err_cnt++;
    end

  // disabled clock holds every output
  freeze_outputs : assert property (@(posedge iclk) disable iff (ireset)
    !iclkena |=> ($stable(owrite) && $stable(owaddr) && $stable(owdat) && $stable(owfull)))
    else begin
      $display("outputs changed while iclkena was low");
      err_cnt++;
    end

  task automatic check_write(input wr_t e);
    assert (owaddr == e.addr) else begin
      $display("[ERROR] owaddr: expected %h, got %h", e.addr, owaddr);
      err_cnt++;
    end
    assert (owdat == e.dat) else begin
      $display("[ERROR] owdat: expected %h, got %h", e.dat, owdat);
      err_cnt++;
    end
    assert (owfull == e.full) else begin
      $display("[ERROR] owfull: expected %h, got %h", e.full, owfull);
      err_cnt++;
    end
    assert (owtag == e.tag) else begin
      $display("[ERROR] owtag: expected %h, got %h", e.tag, owtag);
      err_cnt++;
    end
    assert (ocode_id == e.code) else begin
      $display("[ERROR] ocode_id: expected %h, got %h", e.code, ocode_id);
      err_cnt++;
    end
    assert (e.cyc == ecnt) else begin
      $display("write to address %h came at cycle %0d, not at cycle %0d", owaddr, ecnt, e.cyc);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------
  // monitor, enabled cycles only
  // ------------------------------------------------------------

  always @(posedge iclk) begin : monitor
    wr_t e;
    if (ireset) begin
      busy_run = 0;
    end else if (iclkena) begin
      ecnt = ecnt + 1;
      // busy run length, checked when it ends
      if (obusy) begin
        busy_run = busy_run + 1;
      end else if (busy_run != 0) begin
        assert (busy_run == 3) else begin
          $display("[ERROR] obusy cycles: expected %h, got %h", 3, busy_run);
          err_cnt++;
        end
        busy_run = 0;
      end
      if (owrite) begin
        if (exp_q.size() == 0) begin
          $display("write to address %h while no write was expected", owaddr);
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          check_write(e);
        end
      end else if (exp_q.size() != 0 && exp_q[0].cyc <= ecnt) begin
        $display("expected write at cycle %0d did not happen", exp_q[0].cyc);
        err_cnt++;
        void'(exp_q.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // reference model and stimulus
  // ------------------------------------------------------------

  function automatic logic [`ENC_DAT_W-1:0] rotate_left(input logic [`ENC_DAT_W-1:0] w,
                                                        input int sh);
    logic [`ENC_DAT_W-1:0] r;
    int                    b;
    for (b = 0; b < `ENC_DAT_W; b++) begin
      r[(b + sh) % `ENC_DAT_W] = w[b];
    end
    return r;
  endfunction

  task automatic push_write(input logic [`ENC_ADDR_W-1:0] addr, input logic [`ENC_DAT_W-1:0] dat,
                            input logic full, input logic [`ENC_TAG_W-1:0] tag,
                            input logic [1:0] code, input int cyc);
    wr_t e;
    e.addr = addr;
    e.dat  = dat;
    e.full = full;
    e.tag  = tag;
    e.code = code;
    e.cyc  = cyc;
    exp_q.push_back(e);
  endtask

  // one block of random words
  // hold_at >= 0 drops iclkena for hold_len cycles before that word
  task automatic send_block(input int n_words, input logic [`ENC_TAG_W-1:0] tag,
                            input enc_ctx_pkg::punct_mode_t punct,
                            input enc_ctx_pkg::code_id_t code,
                            input int hold_at, input int hold_len);
    logic [`ENC_DAT_W-1:0]  w;
    logic [`ENC_DAT_W-1:0]  p1;
    logic [`ENC_DAT_W-1:0]  p2;
    logic [`ENC_DAT_W-1:0]  p3;
    logic [`ENC_ADDR_W-1:0] addr;
    logic [31:0]            rnd;
    int                     i;
    int                     k;
    int                     cap;
    p1   = '0;
    p2   = '0;
    p3   = '0;
    addr = '0;
    cap  = 0;
    for (i = 0; i < n_words; i++) begin
      if (i == hold_at) begin
        // garbage on the inputs, must be ignored
        for (k = 0; k < hold_len; k++) begin
          @(negedge iclk);
          rnd     = $random(seed);
          iclkena = 1'b0;
          ival    = 1'b1;
          isof    = 1'b0;
          ieof    = 1'b0;
          idat    = rnd[`ENC_DAT_W-1:0];
        end
      end
      @(negedge iclk);
      rnd      = $random(seed);
      w        = rnd[`ENC_DAT_W-1:0];
      iclkena  = 1'b1;
      ival     = 1'b1;
      isof     = (i == 0);
      ieof     = (i == n_words - 1);
      idat     = w;
      itag     = tag;
      ipunct   = punct;
      icode_id = code;
      // word is taken at the next enabled edge
      cap = ecnt + 1;
      p1  = p1 ^ w;
      p2  = p2 ^ rotate_left(w, i % `ENC_DAT_W);
      if (i % 2 == 0) begin
        p3 = p3 ^ w;
      end
      if (!(punct == enc_ctx_pkg::PUNCT_ON && i < `ENC_PUNCT_WORDS)) begin
        push_write(addr, w, 1'b0, tag, code, cap + 2);
        addr = addr + 1'b1;
      end
    end
    // parity words three to five cycles after eof
    push_write(addr, p1, 1'b0, tag, code, cap + 3);
    push_write(addr + 8'd1, p2, 1'b0, tag, code, cap + 4);
    push_write(addr + 8'd2, p3, 1'b1, tag, code, cap + 5);
    @(negedge iclk);
    ival = 1'b0;
    isof = 1'b0;
    ieof = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge iclk);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge iclk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d writes still missing after %0d cycles", exp_q.size(), limit);
      aborted = 1'b1;
      exp_q.delete();
    end
  endtask

  // counts busy cycles until obusy drops
  task automatic wait_not_busy(input int limit, output int n_busy);
    n_busy = 0;
    while (obusy && n_busy < limit) begin
      @(negedge iclk);
      n_busy++;
    end
    if (obusy) begin
      $display("timeout: obusy still high after %0d cycles", limit);
      aborted = 1'b1;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (err_cnt == err_before && !aborted) begin
      $display("test %0d %s: pass", num, name);
      n_pass++;
    end else begin
      $display("test %0d %s: fail, %0d errors", num, name, err_cnt - err_before);
      n_fail++;
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    int          e0;
    int          j;
    int          nb;
    logic [31:0] rnd;
    seed     = 74107;
    iclk     = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    ival     = 1'b0;
    isof     = 1'b0;
    ieof     = 1'b0;
    idat     = '0;
    itag     = '0;
    ipunct   = enc_ctx_pkg::PUNCT_OFF;
    icode_id = '0;
    ecnt     = 0;
    busy_run = 0;
    err_cnt  = 0;
    n_pass   = 0;
    n_fail   = 0;
    aborted  = 1'b0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;

    e0 = err_cnt;
    send_block(6, 2'd1, enc_ctx_pkg::PUNCT_OFF, 2'd2, -1, 0);
    wait_drain(40);
    report_test(1, "unpunctured block", e0);

    if (!aborted) begin
      e0 = err_cnt;
      for (j = 0; j < 4; j++) begin
        rnd = $random(seed);
        send_block(3 + rnd[2:0], rnd[4:3], enc_ctx_pkg::PUNCT_OFF, rnd[6:5], -1, 0);
        wait_not_busy(20, nb);
      end
      wait_drain(40);
      report_test(2, "parity words", e0);
    end

    if (!aborted) begin
      e0 = err_cnt;
      send_block(7, 2'd2, enc_ctx_pkg::PUNCT_ON, 2'd1, -1, 0);
      wait_not_busy(20, nb);
      // only one data word survives
      send_block(3, 2'd3, enc_ctx_pkg::PUNCT_ON, 2'd3, -1, 0);
      wait_drain(40);
      report_test(3, "puncturing", e0);
    end

    if (!aborted) begin
      e0 = err_cnt;
      // three idle cycles between blocks
      send_block(5, 2'd0, enc_ctx_pkg::PUNCT_OFF, 2'd3, -1, 0);
      idle(2);
      send_block(4, 2'd3, enc_ctx_pkg::PUNCT_ON, 2'd0, -1, 0);
      idle(2);
      send_block(6, 2'd2, enc_ctx_pkg::PUNCT_OFF, 2'd1, -1, 0);
      wait_drain(60);
      report_test(4, "tag and code id", e0);
    end

    if (!aborted) begin
      e0 = err_cnt;
      // reset hits while the tail and parity words of this block are in flight
      send_block(4, 2'd3, enc_ctx_pkg::PUNCT_OFF, 2'd1, -1, 0);
      ireset = 1'b1;
      // writes cut off by the reset never come
      exp_q.delete();
      repeat (10) @(negedge iclk);
      ireset = 1'b0;
      assert (!owrite && !owfull && !obusy) else begin
        $display("[ERROR] owrite/owfull/obusy after reset: expected %h, got %h",
                 3'b000, {owrite, owfull, obusy});
        err_cnt++;
      end
      // monitor flags any write while idle
      idle(20);
      send_block(4, 2'd1, enc_ctx_pkg::PUNCT_OFF, 2'd2, -1, 0);
      wait_not_busy(20, nb);
      assert (nb == 3) else begin
        $display("[ERROR] obusy cycles after eof: expected %h, got %h", 3, nb);
        err_cnt++;
      end
      wait_drain(40);
      report_test(5, "reset and busy", e0);
    end

    if (!aborted) begin
      e0 = err_cnt;
      send_block(8, 2'd1, enc_ctx_pkg::PUNCT_ON, 2'd2, 3, 5);
      wait_not_busy(20, nb);
      send_block(8, 2'd0, enc_ctx_pkg::PUNCT_OFF, 2'd3, 6, 4);
      wait_drain(60);
      report_test(6, "clock enable", e0);
    end

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
    if (err_cnt == 0 && n_fail == 0 && !aborted) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/enc_ctx_pkg.sv
common/enc_word_pkg.sv
enc_sys/enc_sys_path.sv
enc_parity/enc_parity.sv
design/enc_muxout.sv
design/enc_top.sv
tests/enc_tb.sv
